// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dcache_tb
FILELIST = filelist.f
LOG      = sim.log
PASS     = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(TOOL) --lint-only --top-module dcache -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_ram.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache.sv
test/clk_gen.sv
test/cbus_mem_model.sv
test/dcache_tb.sv

// ==== test/cbus_mem_model.sv ====
`default_nettype none

module cbus_mem_model
    import dcache_pkg::*;
#(
    parameter int WORDS = 4096
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         creq_valid,
    input  logic         creq_write,
    input  logic [31:0]  creq_addr,
    input  access_size_t creq_size,
    input  strobe_t      creq_strobe,
    input  word_t        creq_data,
    input  burst_len_t   creq_len,
    output logic         cresp_ready,
    output logic         cresp_last,
    output word_t        cresp_data
);

    word_t       store [WORDS];
    offset_t     cnt;
    logic [11:0] widx;
    integer      seed;

    initial begin
        seed = 71254;
        for (int k = 0; k < WORDS; k++) begin
            store[k] = (32'(k) * 32'h9e3779b1) ^ 32'ha5a5_0000;
        end
    end

    // bursts walk up from the line base
    assign widx       = creq_addr[13:2] + (creq_len == MLEN16 ? 12'(cnt) : 12'd0);
    assign cresp_data = store[widx];
    assign cresp_last = cresp_ready && creq_valid && cnt == offset_t'(creq_len);

    always @(posedge clk) begin
        if (resetn) begin
            cresp_ready <= 1'b0;
            cnt         <= '0;
        end else begin
            // roughly one cycle in four without ready
            cresp_ready <= ($random(seed) & 3) != 0;
            if (creq_valid && cresp_ready) begin
                if (creq_write) begin
                    for (int i = 0; i < 4; i++) begin
                        if (creq_strobe[i]) begin
                            store[widx][8*i +: 8] <= creq_data[8*i +: 8];
                        end
                    end
                end
                cnt <= cresp_last ? offset_t'(0) : cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is active while resetn is high
    initial begin
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/dcache_tb.sv ====
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;

    localparam int N_REQ   = 400;
    localparam int TIMEOUT = N_REQ * 60;

    logic clk, resetn, req_valid, req_uncached, addr_ok, data_ok;
    logic creq_valid, creq_write, cresp_ready, cresp_last;
    logic [31:0] req_addr, creq_addr;
    strobe_t req_strobe, creq_strobe;
    word_t req_data, resp_data, creq_data, cresp_data;
    access_size_t req_size, creq_size;
    burst_len_t creq_len;

    logic [31:0] r_addr [N_REQ];
    strobe_t r_strobe [N_REQ];
    word_t r_data [N_REQ];
    access_size_t r_size [N_REQ];
    logic r_unc [N_REQ];

    // reference model of memory and cache state
    word_t image [4096];
    tag_t m_tag [16][2];
    logic m_valid [16][2];
    logic m_dirty [16][2];
    way_t m_lru [16];

    int exp_id [$];
    int exp_due [$];
    logic exp_read [$];
    word_t exp_rdata [$];
    logic [31:0] bus_addr [$];
    logic bus_write [$];
    access_size_t bus_size [$];
    strobe_t bus_strobe [$];
    word_t bus_data [$];
    burst_len_t bus_len [$];

    integer seed;
    int cycle, issued, responses, beats, errors;
    logic reset_checked;

    clk_gen #(.PERIOD(40), .RESET_CYCLES(16)) u_clk_gen (.clk, .resetn);
    dcache u_dcache (.*);
    cbus_mem_model u_mem (.*);

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input access_size_t exp, input access_size_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_strobe(input string name, input strobe_t exp, input strobe_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input burst_len_t exp, input burst_len_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    function automatic word_t merge(input word_t old, input word_t new_data, input strobe_t strb);
        word_t w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                w[8*i +: 8] = new_data[8*i +: 8];
            end
        end
        return w;
    endfunction

    task automatic set_request(input int i, input logic unc, input tag_t tg, input index_t set,
                               input offset_t off, input strobe_t strb);
        logic [1:0] lane;
        lane = 2'd0;
        r_size[i] = MSIZE4;
        case (strb)
            4'h1, 4'h2, 4'h4, 4'h8: begin
                r_size[i] = MSIZE1;
                lane = strb[1] ? 2'd1 : strb[2] ? 2'd2 : strb[3] ? 2'd3 : 2'd0;
            end
            4'h3: r_size[i] = MSIZE2;
            4'hc: begin
                r_size[i] = MSIZE2;
                lane = 2'd2;
            end
            default: ;
        endcase
        r_addr[i] = {tg, set, off, lane};
        r_strobe[i] = strb;
        r_data[i] = $random(seed);
        r_unc[i] = unc;
    endtask

    task automatic push_beat(input logic [31:0] a, input logic wr, input access_size_t sz,
                             input strobe_t strb, input word_t d, input burst_len_t len);
        bus_addr.push_back(a);
        bus_write.push_back(wr);
        bus_size.push_back(sz);
        bus_strobe.push_back(strb);
        bus_data.push_back(d);
        bus_len.push_back(len);
    endtask

    task automatic model_accept(input int i);
        logic [31:0] a;
        logic [31:0] base;
        index_t idx;
        tag_t tg;
        logic wr, hit;
        way_t w, v;
        a = r_addr[i];
        idx = a[9:6];
        tg = a[31:10];
        wr = |r_strobe[i];
        hit = 1'b0;
        w = '0;
        exp_id.push_back(i);
        exp_read.push_back(!wr);
        exp_rdata.push_back(image[a[13:2]]);
        if (r_unc[i]) begin
            push_beat(a, wr, r_size[i], r_strobe[i], r_data[i], MLEN1);
            exp_due.push_back(-1);
        end else begin
            for (int j = 0; j < 2; j++) begin
                if (m_valid[idx][j] && m_tag[idx][j] == tg) begin
                    hit = 1'b1;
                    w = way_t'(j);
                end
            end
            if (hit) begin
                m_lru[idx] = ~w;
                m_dirty[idx][w] = m_dirty[idx][w] | wr;
                exp_due.push_back(cycle + 2);
            end else begin
                v = m_lru[idx];
                // dirty victim goes out before the refill
                if (m_valid[idx][v] && m_dirty[idx][v]) begin
                    base = {m_tag[idx][v], idx, 6'd0};
                    for (int b = 0; b < 16; b++) begin
                        push_beat(base, 1'b1, MSIZE4, 4'hf, image[base[13:2] + 12'(b)],
                                  MLEN16);
                    end
                end
                for (int b = 0; b < 16; b++) begin
                    push_beat({tg, idx, 6'd0}, 1'b0, MSIZE4, 4'hf, '0, MLEN16);
                end
                m_valid[idx][v] = 1'b1;
                m_tag[idx][v] = tg;
                m_dirty[idx][v] = wr;
                m_lru[idx] = ~v;
                exp_due.push_back(-1);
            end
        end
        if (wr) begin
            image[a[13:2]] = merge(image[a[13:2]], r_data[i], r_strobe[i]);
        end
    endtask

    task automatic check_beat();
        if (bus_addr.size() == 0) begin
            $display("bus beat at cycle %0d with no transfer expected", cycle);
            errors++;
        end else begin
            check_addr($sformatf("bus address, beat %0d", beats), bus_addr.pop_front(), creq_addr);
            check_flag($sformatf("bus write, beat %0d", beats), bus_write.pop_front(), creq_write);
            check_size($sformatf("bus size, beat %0d", beats), bus_size.pop_front(), creq_size);
            check_strobe($sformatf("bus strobe, beat %0d", beats), bus_strobe.pop_front(),
                         creq_strobe);
            check_len($sformatf("bus length, beat %0d", beats), bus_len.pop_front(), creq_len);
            if (creq_write) begin
                check_word($sformatf("bus data, beat %0d", beats), bus_data.pop_front(), creq_data);
            end else begin
                void'(bus_data.pop_front());
            end
        end
        beats++;
    endtask

    task automatic check_response();
        int id, due;
        word_t exp;
        logic rd;
        if (exp_id.size() == 0) begin
            $display("data_ok at cycle %0d without an outstanding request", cycle);
            errors++;
        end else begin
            id = exp_id.pop_front();
            due = exp_due.pop_front();
            exp = exp_rdata.pop_front();
            rd = exp_read.pop_front();
            if (due >= 0 && due != cycle) begin
                $display("hit of request %0d answered at cycle %0d, not at %0d", id, cycle, due);
                errors++;
            end
            if (rd) begin
                check_word($sformatf("read data of request %0d", id), exp, resp_data);
            end
        end
        responses++;
    endtask

    task automatic drive_request(input int i);
        req_valid <= 1'b1;
        req_addr <= r_addr[i];
        req_strobe <= r_strobe[i];
        req_data <= r_data[i];
        req_size <= r_size[i];
        req_uncached <= r_unc[i];
    endtask

    task automatic finish_run();
        if (bus_addr.size() != 0) begin
            $display("%0d expected bus beats never appeared", bus_addr.size());
            errors++;
        end
        $display("errors %0d, requests %0d, responses %0d, bus beats %0d",
                 errors, issued, responses, beats);
        if (errors == 0 && responses == N_REQ) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        seed = 71254;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_data = '0;
        req_size = MSIZE4;
        req_uncached = 1'b0;
        cycle = 0;
        issued = 0;
        responses = 0;
        beats = 0;
        errors = 0;
        reset_checked = 1'b0;
        for (int k = 0; k < 4096; k++) begin
            image[k] = (32'(k) * 32'h9e3779b1) ^ 32'ha5a5_0000;
        end
        for (int s = 0; s < 16; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        // two tags alternate in set 0, then a third one evicts
        set_request(0, 1'b0, 22'd1, 4'd0, 4'd0, 4'hf);
        set_request(1, 1'b0, 22'd2, 4'd0, 4'd1, 4'hf);
        set_request(2, 1'b0, 22'd1, 4'd0, 4'd0, 4'h0);
        set_request(3, 1'b0, 22'd3, 4'd0, 4'd2, 4'hf);
        set_request(4, 1'b0, 22'd2, 4'd0, 4'd1, 4'h0);
        set_request(5, 1'b0, 22'd1, 4'd0, 4'd0, 4'h0);
        for (int i = 6; i < N_REQ; i++) begin
            if (($random(seed) & 7) == 0) begin
                set_request(i, 1'b1, 22'd8, index_t'($random(seed)), offset_t'($random(seed)),
                            (($random(seed) & 1) != 0) ? 4'h0 : strobe_t'($random(seed)));
            end else begin
                set_request(i, 1'b0, 22'(1 + $unsigned($random(seed)) % 3),
                            index_t'($random(seed) & 3), offset_t'($random(seed)),
                            (($random(seed) & 1) != 0) ? 4'h0 : strobe_t'($random(seed)));
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycle, responses, N_REQ);
            errors++;
            finish_run();
        end else if (resetn) begin
            req_valid <= 1'b0;
        end else begin
            if (!reset_checked) begin
                check_flag("addr_ok after reset", 1'b1, addr_ok);
                check_flag("data_ok after reset", 1'b0, data_ok);
                check_flag("creq_valid after reset", 1'b0, creq_valid);
                reset_checked = 1'b1;
            end
            if (creq_valid && cresp_ready) begin
                check_beat();
            end
            if (data_ok) begin
                check_response();
            end
            if (req_valid && addr_ok) begin
                model_accept(issued);
                issued++;
            end
            // a request is held until accepted
            if (!req_valid || addr_ok) begin
                if (issued < N_REQ && ($random(seed) & 3) != 0) begin
                    drive_request(issued);
                end else begin
                    req_valid <= 1'b0;
                end
            end
            if (responses == N_REQ) begin
                finish_run();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache.sv ====
`default_nettype none

`include "dcache_macros.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      req_valid,
    input  logic [`DC_ADDR_WIDTH-1:0] req_addr,
    input  strobe_t                   req_strobe,
    input  word_t                     req_data,
    input  access_size_t              req_size,
    input  logic                      req_uncached,
    output logic                      addr_ok,
    output logic                      data_ok,
    output word_t                     resp_data,

    output logic                      creq_valid,
    output logic                      creq_write,
    output logic [`DC_ADDR_WIDTH-1:0] creq_addr,
    output access_size_t              creq_size,
    output strobe_t                   creq_strobe,
    output word_t                     creq_data,
    output burst_len_t                creq_len,
    input  logic                      cresp_ready,
    input  logic                      cresp_last,
    input  word_t                     cresp_data
);

    logic                      accept;
    logic                      hit;
    logic                      lookup_hit;
    way_t                      hit_way;
    way_t                      victim_way;
    logic                      victim_dirty;
    tag_t                      victim_tag;

    logic                      stage_valid;
    logic                      stage_hit;
    way_t                      stage_way;
    way_t                      miss_way;
    logic [`DC_ADDR_WIDTH-1:0] stage_addr;
    strobe_t                   stage_strobe;
    word_t                     stage_data;
    access_size_t              stage_size;
    logic                      stage_uncached;
    index_t                    stage_index;
    logic                      resp_uncached;

    logic                      start;
    logic                      hit_access;
    logic                      replay;
    logic                      fill;
    logic                      refill_fill;
    logic                      done;
    word_t                     uncached_rdata;

    logic                      ram_en;
    strobe_t                   ram_strobe;
    ram_addr_t                 ram_addr;
    word_t                     ram_wdata;
    logic                      a_en;
    ram_addr_t                 a_addr;
    word_t                     a_rdata;
    logic                      b_en;
    strobe_t                   b_strobe;
    word_t                     b_rdata;

    logic [1:0]                outstanding;

    assign accept      = req_valid & addr_ok;
    assign lookup_hit  = hit & ~req_uncached;
    assign stage_index = stage_addr[INDEX_LSB +: INDEX_BITS];
    assign hit_access  = stage_valid & stage_hit;
    assign start       = stage_valid & ~stage_hit;
    assign replay      = done & ~stage_uncached;

    always_ff @(posedge clk) begin
        if (resetn) begin
            stage_valid <= 1'b0;
            addr_ok     <= 1'b1;
            data_ok     <= 1'b0;
            outstanding <= '0;
        end else begin
            stage_valid <= accept;
            data_ok     <= hit_access | done;
            outstanding <= outstanding + 2'(accept) - 2'(data_ok);
            // miss or uncached blocks new requests until done
            if (accept && !lookup_hit) begin
                addr_ok <= 1'b0;
            end else if (done) begin
                addr_ok <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_addr     <= req_addr;
            stage_strobe   <= req_strobe;
            stage_data     <= req_data;
            stage_size     <= req_size;
            stage_uncached <= req_uncached;
            stage_hit      <= lookup_hit;
            stage_way      <= hit_way;
        end
        if (start) begin
            miss_way <= victim_way;
        end
        resp_uncached <= stage_uncached;
    end

    dcache_tag_store u_tag_store (
        .clk,
        .resetn,
        .lookup_index (req_addr[INDEX_LSB +: INDEX_BITS]),
        .lookup_tag   (req_addr[TAG_LSB +: TAG_BITS]),
        .stage_index,
        .touch        (hit_access),
        .touch_way    (stage_way),
        .touch_write  (|stage_strobe),
        .fill,
        .fill_tag     (stage_addr[TAG_LSB +: TAG_BITS]),
        .hit,
        .hit_way,
        .victim_way,
        .victim_dirty,
        .victim_tag
    );

    // port a for hits and the replay, port b for line traffic
    assign a_en     = hit_access | replay;
    assign a_addr   = {stage_hit ? stage_way : miss_way, stage_index,
                       stage_addr[BYTE_BITS +: OFFSET_BITS]};
    assign b_en     = refill_fill & ram_en;
    assign b_strobe = refill_fill ? ram_strobe : '0;

    dcache_data_ram #(
        .ADDR_BITS ($bits(ram_addr_t))
    ) u_data_ram (
        .clk,
        .a_en,
        .a_strobe (stage_strobe),
        .a_addr,
        .a_wdata  (stage_data),
        .b_en,
        .b_strobe,
        .b_addr   (ram_addr),
        .b_wdata  (ram_wdata),
        .a_rdata,
        .b_rdata
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk,
        .resetn,
        .start,
        .stage_addr,
        .stage_strobe,
        .stage_data,
        .stage_size,
        .stage_uncached,
        .victim_way,
        .victim_dirty,
        .victim_tag,
        .ram_rdata (b_rdata),
        .ram_en,
        .ram_strobe,
        .ram_addr,
        .ram_wdata,
        .fill,
        .refill_fill,
        .done,
        .uncached_rdata,
        .creq_valid,
        .creq_write,
        .creq_addr,
        .creq_size,
        .creq_strobe,
        .creq_data,
        .creq_len,
        .cresp_ready,
        .cresp_last,
        .cresp_data
    );

    assign resp_data = resp_uncached ? uncached_rdata : a_rdata;

    // every response belongs to an accepted request
    assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> outstanding != 2'd0);

endmodule

`default_nettype wire

// ==== verilog/dcache_data_ram.sv ====
`default_nettype none

module dcache_data_ram
    import dcache_pkg::*;
#(
    parameter int ADDR_BITS = $bits(ram_addr_t)
) (
    input  logic      clk,

    input  logic      a_en,
    input  strobe_t   a_strobe,
    input  ram_addr_t a_addr,
    input  word_t     a_wdata,

    input  logic      b_en,
    input  strobe_t   b_strobe,
    input  ram_addr_t b_addr,
    input  word_t     b_wdata,

    output word_t     a_rdata,
    output word_t     b_rdata
);

    word_t mem [2**ADDR_BITS];

    // read returns the old word on a write
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            for (int i = 0; i < $bits(strobe_t); i++) begin
                if (a_strobe[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
            for (int i = 0; i < $bits(strobe_t); i++) begin
                if (b_strobe[i]) begin
                    mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// two-way, 16 sets, 16-word lines
`define DC_WAYS       2
`define DC_SETS       16
`define DC_LINE_WORDS 16
`define DC_WORD_BYTES 4

// byte address
`define DC_ADDR_WIDTH 32

`endif

// ==== verilog/dcache_miss_ctrl.sv ====
`default_nettype none

`include "dcache_macros.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      start,
    input  logic [`DC_ADDR_WIDTH-1:0] stage_addr,
    input  strobe_t                   stage_strobe,
    input  word_t                     stage_data,
    input  access_size_t              stage_size,
    input  logic                      stage_uncached,
    input  way_t                      victim_way,
    input  logic                      victim_dirty,
    input  tag_t                      victim_tag,
    input  word_t                     ram_rdata,

    output logic                      ram_en,
    output strobe_t                   ram_strobe,
    output ram_addr_t                 ram_addr,
    output word_t                     ram_wdata,
    output logic                      fill,
    output logic                      refill_fill,
    output logic                      done,
    output word_t                     uncached_rdata,

    output logic                      creq_valid,
    output logic                      creq_write,
    output logic [`DC_ADDR_WIDTH-1:0] creq_addr,
    output access_size_t              creq_size,
    output strobe_t                   creq_strobe,
    output word_t                     creq_data,
    output burst_len_t                creq_len,
    input  logic                      cresp_ready,
    input  logic                      cresp_last,
    input  word_t                     cresp_data
);

    miss_state_t state;
    way_t        way_q;
    tag_t        wb_tag;
    offset_t     beat;
    offset_t     rd_ptr;
    offset_t     cap_ptr;
    logic        rd_busy;
    logic        cap_valid;
    logic        wb_go;
    word_t       buffer [`DC_LINE_WORDS];
    word_t       wb_word;
    index_t      index;
    tag_t        req_tag;
    logic        beat_done;
    logic        last_beat;

    assign index     = stage_addr[INDEX_LSB +: INDEX_BITS];
    assign req_tag   = stage_addr[TAG_LSB +: TAG_BITS];
    assign beat_done = creq_valid & cresp_ready;
    assign last_beat = beat_done & cresp_last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= IDLE;
            done      <= 1'b0;
            rd_busy   <= 1'b0;
            cap_valid <= 1'b0;
            wb_go     <= 1'b0;
        end else begin
            done      <= 1'b0;
            cap_valid <= state == WRITEBACK && rd_busy;
            // bus starts one cycle after the first ram read
            wb_go     <= state == WRITEBACK;
            case (state)
                IDLE: begin
                    if (start) begin
                        rd_busy <= 1'b1;
                        if (stage_uncached) begin
                            state <= UNCACHED;
                        end else if (victim_dirty) begin
                            state <= WRITEBACK;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                WRITEBACK: begin
                    if (rd_busy && rd_ptr == '1) begin
                        rd_busy <= 1'b0;
                    end
                    if (last_beat) begin
                        state <= FETCH;
                    end
                end
                FETCH, UNCACHED: begin
                    if (last_beat) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cap_ptr <= rd_ptr;
        if (cap_valid) begin
            buffer[cap_ptr] <= ram_rdata;
        end
        if (state == IDLE && start) begin
            way_q  <= victim_way;
            wb_tag <= victim_tag;
            rd_ptr <= '0;
            beat   <= '0;
        end else begin
            if (state == WRITEBACK && rd_busy) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // wraps to zero for the fetch after write-back
            if (beat_done) begin
                beat <= beat + 1'b1;
            end
        end
        if (state == UNCACHED && last_beat) begin
            uncached_rdata <= cresp_data;
        end
    end

    // word just read from the ram is not in the buffer yet
    assign wb_word = (cap_valid && cap_ptr == beat) ? ram_rdata : buffer[beat];

    always_comb begin
        creq_valid  = 1'b0;
        creq_write  = 1'b0;
        creq_addr   = {req_tag, index, {(OFFSET_BITS+BYTE_BITS){1'b0}}};
        creq_size   = MSIZE4;
        creq_strobe = '1;
        creq_data   = wb_word;
        creq_len    = MLEN16;
        ram_en      = 1'b0;
        ram_strobe  = '0;
        ram_addr    = {way_q, index, rd_ptr};
        ram_wdata   = cresp_data;
        case (state)
            WRITEBACK: begin
                creq_valid = wb_go;
                creq_write = 1'b1;
                creq_addr  = {wb_tag, index, {(OFFSET_BITS+BYTE_BITS){1'b0}}};
                ram_en     = rd_busy;
            end
            FETCH: begin
                creq_valid = 1'b1;
                ram_en     = beat_done;
                ram_strobe = '1;
                ram_addr   = {way_q, index, beat};
            end
            UNCACHED: begin
                creq_valid  = 1'b1;
                creq_write  = |stage_strobe;
                creq_addr   = stage_addr;
                creq_size   = stage_size;
                creq_strobe = stage_strobe;
                creq_data   = stage_data;
                creq_len    = MLEN1;
            end
            default: begin
            end
        endcase
    end

    assign refill_fill = state == WRITEBACK || state == FETCH;
    assign fill        = state == FETCH && last_beat;

    // address held for a whole burst
    assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !(cresp_ready && cresp_last) |=> $stable(creq_addr));

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    localparam int BYTE_BITS   = $clog2(`DC_WORD_BYTES);
    localparam int OFFSET_BITS = $clog2(`DC_LINE_WORDS);
    localparam int INDEX_BITS  = $clog2(`DC_SETS);
    localparam int WAY_BITS    = $clog2(`DC_WAYS);
    localparam int TAG_BITS    = `DC_ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // address field positions
    localparam int INDEX_LSB = BYTE_BITS + OFFSET_BITS;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_BITS;

    typedef logic [8*`DC_WORD_BYTES-1:0] word_t;
    typedef logic [`DC_WORD_BYTES-1:0]   strobe_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [OFFSET_BITS-1:0]      offset_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [WAY_BITS-1:0]         way_t;

    // {way, index, offset}
    typedef logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] ram_addr_t;

    typedef enum logic [2:0] {
        MSIZE1 = 3'd0,
        MSIZE2 = 3'd1,
        MSIZE4 = 3'd2
    } access_size_t;

    // beat count minus one
    typedef enum logic [3:0] {
        MLEN1  = 4'd0,
        MLEN16 = 4'd15
    } burst_len_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FETCH,
        UNCACHED
    } miss_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_tag_store.sv ====
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,

    input  index_t lookup_index,
    input  tag_t   lookup_tag,

    input  index_t stage_index,
    input  logic   touch,
    input  way_t   touch_way,
    input  logic   touch_write,
    input  logic   fill,
    input  tag_t   fill_tag,

    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    tag_t                              tags  [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]               valid [`DC_SETS];
    way_t [`DC_SETS-1:0]               lru;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty;
    index_t                            sweep;

    // one set per cycle during reset
    always_ff @(posedge clk) begin
        if (resetn) begin
            sweep        <= sweep + 1'b1;
            valid[sweep] <= '0;
        end else begin
            sweep <= '0;
            if (fill) begin
                valid[stage_index][victim_way] <= 1'b1;
                tags[stage_index][victim_way]  <= fill_tag;
            end
        end
    end

    // lru bit names the next victim
    always_ff @(posedge clk) begin
        if (resetn) begin
            lru   <= '0;
            dirty <= '0;
        end else if (fill) begin
            lru[stage_index]               <= ~victim_way;
            dirty[stage_index][victim_way] <= touch_write;
        end else if (touch) begin
            lru[stage_index] <= ~touch_way;
            if (touch_write) begin
                dirty[stage_index][touch_way] <= 1'b1;
            end
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (valid[lookup_index][w] && tags[lookup_index][w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign victim_way   = lru[stage_index];
    assign victim_dirty = valid[stage_index][victim_way] & dirty[stage_index][victim_way];
    assign victim_tag   = tags[stage_index][victim_way];

endmodule

`default_nettype wire
